/* common/bk_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared sizes for the backup RAM save and restore engine
// Data and address types for the host, staging and memory sides
// Storage block layout for backup RAM and cartridge area
//////////////////////////////////////////////////////////////////////

package bk_pkg;

	// Data units
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;

	// One storage block, as bytes and as host words
	localparam int BLOCK_BYTES = 512;
	localparam int HOST_WORDS  = BLOCK_BYTES / 2;

	typedef logic [$clog2(HOST_WORDS)-1:0]  host_addr_t;
	typedef logic [$clog2(BLOCK_BYTES)-1:0] stage_addr_t;

	// Internal backup RAM, 8 KB
	localparam int BRAM_BLOCKS    = 16;
	localparam int BRAM_BYTES     = BRAM_BLOCKS * BLOCK_BYTES;
	localparam int BRAM_WORD_BITS = $clog2(BRAM_BYTES / 2);

	typedef logic [$clog2(BRAM_BYTES)-1:0] bram_addr_t;

	// Cartridge save area, kept small
	localparam int CART_BLOCKS = 4;
	localparam int CART_BYTES  = CART_BLOCKS * BLOCK_BYTES;

	typedef logic [$clog2(CART_BLOCKS)-1:0] cart_blk_t;

	// Storage block numbers
	typedef logic [10:0] lba_t;

	// Last block of each layout
	localparam lba_t LAST_BRAM_LBA = lba_t'(BRAM_BLOCKS - 1);
	localparam lba_t LAST_CART_LBA = lba_t'(BRAM_BLOCKS + CART_BLOCKS - 1);

	// External memory byte address covers the cartridge area
	typedef logic [$clog2(CART_BYTES)-1:0] mem_addr_t;

endpackage

/* common/block_xfer_if.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Block transfer handshake between save/load FSM and staging stepper
// start is held until done, done is held until start falls
//////////////////////////////////////////////////////////////////////

interface block_xfer_if;
	import bk_pkg::*;

	// Held for a whole block
	logic      start;
	// High when external memory is written from staging
	logic      loading;
	// Cartridge block, upper bits of the memory address
	cart_blk_t block;
	// Last byte done
	logic      done;

	modport ctrl (
		output start,
		output loading,
		output block,
		input  done
	);

	modport step (
		input  start,
		input  loading,
		input  block,
		output done
	);

endinterface

/* common/host_buf_if.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Host buffer word port, one instance per RAM
// Word address width set per RAM
//////////////////////////////////////////////////////////////////////

interface host_buf_if #(
	parameter int ADDR_BITS = 8
);
	import bk_pkg::*;

	logic [ADDR_BITS-1:0] addr;
	word_t                wdata;
	logic                 we;
	// One cycle after addr
	word_t                rdata;

	modport ctrl (
		output addr,
		output wdata,
		output we,
		input  rdata
	);

	modport ram (
		input  addr,
		input  wdata,
		input  we,
		output rdata
	);

endinterface

/* hdl/ram_dual_width.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Dual-port RAM, byte port and 16-bit word port
// Words are little-endian pairs of bytes
//////////////////////////////////////////////////////////////////////

module ram_dual_width #(
	parameter int DEPTH_BYTES = 512
) (
	input  logic                           clk_sys,
	input  logic [$clog2(DEPTH_BYTES)-1:0] byte_addr,
	input  bk_pkg::byte_t                  byte_wdata,
	input  logic                           byte_we,
	output bk_pkg::byte_t                  byte_rdata,
	host_buf_if.ram                        host
);
	import bk_pkg::*;

	word_t mem [DEPTH_BYTES/2];

	logic [$clog2(DEPTH_BYTES)-2:0] byte_word;
	logic                           byte_hi;

	assign byte_word = byte_addr[$clog2(DEPTH_BYTES)-1:1];
	assign byte_hi   = byte_addr[0];

	// Both ports in one block, each read takes one cycle
	always_ff @(posedge clk_sys) begin
		if (byte_we) begin
			if (byte_hi)
				mem[byte_word][15:8] <= byte_wdata;
			else
				mem[byte_word][7:0] <= byte_wdata;
		end
		if (host.we)
			mem[host.addr] <= host.wdata;

		if (byte_hi)
			byte_rdata <= mem[byte_word][15:8];
		else
			byte_rdata <= mem[byte_word][7:0];
		host.rdata <= mem[host.addr];
	end

	// Word view needs whole byte pairs
	if (DEPTH_BYTES % 2 != 0) begin : g_depth_check
		$error("DEPTH_BYTES must be even");
	end

endmodule

/* hdl/stage_stepper.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Staging stepper for one cartridge block
// Moves 512 bytes between staging buffer and external memory
//////////////////////////////////////////////////////////////////////

module stage_stepper (
	input  logic                clk_sys,
	input  logic                reset,
	block_xfer_if.step          xfer,
	output bk_pkg::stage_addr_t stage_addr,
	input  bk_pkg::byte_t       stage_rdata,
	output bk_pkg::byte_t       stage_wdata,
	output logic                stage_we,
	output logic                mem_valid,
	output logic                mem_write,
	output bk_pkg::mem_addr_t   mem_addr,
	output bk_pkg::byte_t       mem_wdata,
	input  logic                mem_ready,
	input  bk_pkg::byte_t       mem_rdata
);
	import bk_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_READ, S_XFER, S_DONE} state_t;

	state_t      state;
	stage_addr_t idx;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= S_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (xfer.start) begin
						idx   <= '0;
						state <= S_READ;
					end
				end
				// Staging read latency
				S_READ: state <= S_XFER;
				S_XFER: begin
					if (mem_ready) begin
						if (&idx) begin
							state <= S_DONE;
						end else begin
							idx   <= idx + stage_addr_t'(1);
							state <= S_READ;
						end
					end
				end
				S_DONE: begin
					if (!xfer.start)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Address holds through the handshake, so read data holds too
	assign stage_addr = idx;
	assign mem_addr   = {xfer.block, idx};
	assign mem_wdata  = stage_rdata;
	assign mem_write  = xfer.loading;
	assign mem_valid  = state == S_XFER;

	// Saving writes the accepted byte into staging
	assign stage_wdata = mem_rdata;
	assign stage_we    = mem_valid & mem_ready & ~xfer.loading;

	assign xfer.done = state == S_DONE;

	a_mem_hold: assert property (@(posedge clk_sys) disable iff (reset)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata));

endmodule

/* control/bk_control.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Backup RAM save/load FSM
// Enable latch, request edges, autosave and change tracking
// Block walk and host buffer routing to backup RAM or staging
//////////////////////////////////////////////////////////////////////

module bk_control (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               img_mounted,
	input  logic               img_readonly,
	input  logic               bk_load,
	input  logic               bk_save,
	input  logic               autosave,
	input  logic               osd_status,
	input  logic               cart_en,
	input  logic               console_we,
	input  logic               cart_write,
	output bk_pkg::lba_t       sd_lba,
	output logic               sd_rd,
	output logic               sd_wr,
	input  logic               sd_ack,
	input  bk_pkg::host_addr_t sd_buff_addr,
	input  bk_pkg::word_t      sd_buff_dout,
	input  logic               sd_buff_wr,
	output bk_pkg::word_t      sd_buff_din,
	host_buf_if.ctrl           bram_buf,
	host_buf_if.ctrl           stage_buf,
	block_xfer_if.ctrl         xfer,
	output logic               bk_busy,
	output logic               bk_reload,
	output logic               sav_pending
);
	import bk_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_HOST, ST_STEP} state_t;

	state_t state;
	logic   bk_ena;
	logic   loading;
	logic   with_cart;
	logic   old_load;
	logic   old_save;
	logic   old_save_a;
	logic   old_ack;
	logic   old_change;
	logic   change;
	logic   save_a;
	logic   load_rise;
	logic   start_req;
	logic   ack_rise;
	logic   ack_fall;
	logic   in_cart;
	logic   next_cart;
	logic   last_block;
	lba_t   cart_lba;

	assign change    = console_we | cart_write;
	assign save_a    = autosave & osd_status;
	assign load_rise = ~old_load & bk_load;
	assign ack_rise  = ~old_ack & sd_ack;
	assign ack_fall  = old_ack & ~sd_ack;

	// Autosave only when the menu closes with something to save
	assign start_req = bk_ena & (load_rise | (~old_save & bk_save) |
		(~old_save_a & save_a & sav_pending));

	assign in_cart    = sd_lba >= lba_t'(BRAM_BLOCKS);
	assign next_cart  = sd_lba >= LAST_BRAM_LBA;
	assign last_block = with_cart ? (sd_lba == LAST_CART_LBA) : (sd_lba == LAST_BRAM_LBA);
	assign cart_lba   = sd_lba - lba_t'(BRAM_BLOCKS);

	//////////////////////////////////////////////////////////////////////
	// Host buffer routing
	//////////////////////////////////////////////////////////////////////

	assign bram_buf.addr  = {sd_lba[$clog2(BRAM_BLOCKS)-1:0], sd_buff_addr};
	assign bram_buf.wdata = sd_buff_dout;
	assign bram_buf.we    = sd_buff_wr & sd_ack & ~in_cart;

	assign stage_buf.addr  = sd_buff_addr;
	assign stage_buf.wdata = sd_buff_dout;
	assign stage_buf.we    = sd_buff_wr & sd_ack & in_cart;

	// sd_lba only moves after ack falls, so the read stays routed
	assign sd_buff_din = in_cart ? stage_buf.rdata : bram_buf.rdata;

	assign xfer.loading = loading;
	assign xfer.block   = cart_blk_t'(cart_lba);

	//////////////////////////////////////////////////////////////////////
	// Enable and change tracking
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
			old_change  <= 1'b0;
		end else begin
			old_change <= change;
			// A read-only image turns saving off again
			if (img_mounted)
				bk_ena <= ~img_readonly;
			if (~old_change & change)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Block walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= ST_IDLE;
			loading    <= 1'b0;
			with_cart  <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			xfer.start <= 1'b0;
			bk_busy    <= 1'b0;
			bk_reload  <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_save_a <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_load   <= bk_load;
			old_save   <= bk_save;
			old_save_a <= save_a;
			old_ack    <= sd_ack;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (start_req) begin
						state     <= ST_HOST;
						bk_busy   <= 1'b1;
						bk_reload <= load_rise;
						loading   <= load_rise;
						with_cart <= cart_en;
						sd_lba    <= '0;
						sd_rd     <= load_rise;
						sd_wr     <= ~load_rise;
					end
				end

				ST_HOST: begin
					if (ack_fall) begin
						if (in_cart && loading) begin
							// Staged block goes out to memory
							xfer.start <= 1'b1;
							state      <= ST_STEP;
						end else if (last_block) begin
							state     <= ST_IDLE;
							bk_busy   <= 1'b0;
							bk_reload <= 1'b0;
						end else begin
							sd_lba <= sd_lba + lba_t'(1);
							if (loading) begin
								sd_rd <= 1'b1;
							end else if (next_cart) begin
								// Fill staging before the host write
								xfer.start <= 1'b1;
								state      <= ST_STEP;
							end else begin
								sd_wr <= 1'b1;
							end
						end
					end
				end

				ST_STEP: begin
					if (xfer.done) begin
						xfer.start <= 1'b0;
						if (!loading) begin
							sd_wr <= 1'b1;
							state <= ST_HOST;
						end else if (last_block) begin
							state     <= ST_IDLE;
							bk_busy   <= 1'b0;
							bk_reload <= 1'b0;
						end else begin
							sd_lba <= sd_lba + lba_t'(1);
							sd_rd  <= 1'b1;
							state  <= ST_HOST;
						end
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	// The stepper only ever serves cartridge blocks
	a_step_cart: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(xfer.start) |-> sd_lba >= lba_t'(BRAM_BLOCKS));

endmodule

/* hdl/bram_backup_top.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Backup RAM save and restore engine, top level
// Controller, backup RAM, staging buffer and staging stepper
//////////////////////////////////////////////////////////////////////

module bram_backup_top (
	input  logic               clk_sys,
	input  logic               reset,
	// Image and menu
	input  logic               img_mounted,
	input  logic               img_readonly,
	input  logic               bk_load,
	input  logic               bk_save,
	input  logic               autosave,
	input  logic               osd_status,
	input  logic               cart_en,
	// Console side
	input  bk_pkg::bram_addr_t console_addr,
	input  bk_pkg::byte_t      console_wdata,
	input  logic               console_we,
	output bk_pkg::byte_t      console_rdata,
	input  logic               cart_write,
	// Storage host
	output bk_pkg::lba_t       sd_lba,
	output logic               sd_rd,
	output logic               sd_wr,
	input  logic               sd_ack,
	input  bk_pkg::host_addr_t sd_buff_addr,
	input  bk_pkg::word_t      sd_buff_dout,
	input  logic               sd_buff_wr,
	output bk_pkg::word_t      sd_buff_din,
	// External memory
	output logic               mem_valid,
	output logic               mem_write,
	output bk_pkg::mem_addr_t  mem_addr,
	output bk_pkg::byte_t      mem_wdata,
	input  logic               mem_ready,
	input  bk_pkg::byte_t      mem_rdata,
	// Status
	output logic               bk_busy,
	output logic               bk_reload,
	output logic               sav_pending
);
	import bk_pkg::*;

	stage_addr_t stage_addr;
	byte_t       stage_rdata;
	byte_t       stage_wdata;
	logic        stage_we;

	host_buf_if #(.ADDR_BITS(BRAM_WORD_BITS))       bram_buf ();
	host_buf_if #(.ADDR_BITS($bits(host_addr_t)))   stage_buf ();
	block_xfer_if                                   xfer ();

	bk_control u_control (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.osd_status   (osd_status),
		.cart_en      (cart_en),
		.console_we   (console_we),
		.cart_write   (cart_write),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din),
		.bram_buf     (bram_buf.ctrl),
		.stage_buf    (stage_buf.ctrl),
		.xfer         (xfer.ctrl),
		.bk_busy      (bk_busy),
		.bk_reload    (bk_reload),
		.sav_pending  (sav_pending)
	);

	// 8 KB backup RAM, console on the byte port
	ram_dual_width #(.DEPTH_BYTES(BRAM_BYTES)) u_bram (
		.clk_sys    (clk_sys),
		.byte_addr  (console_addr),
		.byte_wdata (console_wdata),
		.byte_we    (console_we),
		.byte_rdata (console_rdata),
		.host       (bram_buf.ram)
	);

	// One block of staging for the cartridge area
	ram_dual_width #(.DEPTH_BYTES(BLOCK_BYTES)) u_stage (
		.clk_sys    (clk_sys),
		.byte_addr  (stage_addr),
		.byte_wdata (stage_wdata),
		.byte_we    (stage_we),
		.byte_rdata (stage_rdata),
		.host       (stage_buf.ram)
	);

	stage_stepper u_stepper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.xfer        (xfer.step),
		.stage_addr  (stage_addr),
		.stage_rdata (stage_rdata),
		.stage_wdata (stage_wdata),
		.stage_we    (stage_we),
		.mem_valid   (mem_valid),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_ready   (mem_ready),
		.mem_rdata   (mem_rdata)
	);

endmodule

/* bench/tb_bram_backup.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Testbench for the backup RAM save and restore engine
// Storage host model, external memory model, random stimulus
// Five tests checked against byte models of image, RAM and memory
//////////////////////////////////////////////////////////////////////

module tb_bram_backup;
	import bk_pkg::*;

	localparam int IMG_BLOCKS   = BRAM_BLOCKS + CART_BLOCKS;
	localparam int IMG_BYTES    = IMG_BLOCKS * BLOCK_BYTES;
	localparam int HOST_DLY_MAX = 6;
	localparam int GAP_MAX      = 2;
	localparam int MAX_STALL    = 3;
	localparam int QUIET_CYC    = 50;

	// Worst case for one host block and one staged block
	localparam int HOST_BLOCK_CYC = HOST_DLY_MAX + HOST_WORDS * (2 + GAP_MAX) + 8;
	localparam int STEP_BLOCK_CYC = BLOCK_BYTES * (3 + MAX_STALL) + 8;
	// Two backup-only saves, two full transfers, console fill and readback
	localparam int CYCLE_LIMIT = (2 * BRAM_BLOCKS + 2 * IMG_BLOCKS) * HOST_BLOCK_CYC +
		2 * CART_BLOCKS * STEP_BLOCK_CYC + 3 * BRAM_BYTES + 4 * QUIET_CYC + 2000;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        img_mounted;
	logic        img_readonly;
	logic        bk_load;
	logic        bk_save;
	logic        autosave;
	logic        osd_status;
	logic        cart_en;
	bram_addr_t  console_addr;
	byte_t       console_wdata;
	logic        console_we;
	byte_t       console_rdata;
	logic        cart_write;
	lba_t        sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        sd_ack;
	host_addr_t  sd_buff_addr;
	word_t       sd_buff_dout;
	logic        sd_buff_wr;
	word_t       sd_buff_din;
	logic        mem_valid;
	logic        mem_write;
	mem_addr_t   mem_addr;
	byte_t       mem_wdata;
	logic        mem_ready;
	byte_t       mem_rdata;
	logic        bk_busy;
	logic        bk_reload;
	logic        sav_pending;

	// Models of storage image, backup RAM contents and external memory
	byte_t img [IMG_BYTES];
	byte_t bram_ref [BRAM_BYTES];
	byte_t mem_model [CART_BYTES];
	lba_t  lba_log [$];

	string test_name = "reset";
	int    error_count = 0;
	int    errors_at_start = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    cycle_count = 0;

	bram_backup_top u_dut (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the engine never went idle", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Check and report helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_val(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			$display("Error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%s: %s", test_name, what);
			error_count++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name       = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count != errors_at_start) begin
			tests_failed++;
			$display("%s: %0d errors", test_name, error_count - errors_at_start);
		end else begin
			$display("%s: ok", test_name);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Storage host model
	//////////////////////////////////////////////////////////////////////

	task automatic serve_block(input bit to_dut, input lba_t lba);
		int    base;
		word_t w;
		lba_log.push_back(lba);
		check_true(int'(lba) < IMG_BLOCKS, "host request beyond the image");
		base = (int'(lba) % IMG_BLOCKS) * BLOCK_BYTES;
		repeat ($urandom_range(1, HOST_DLY_MAX)) @(posedge clk_sys);
		sd_ack <= 1'b1;
		@(posedge clk_sys);
		for (int i = 0; i < HOST_WORDS; i++) begin
			sd_buff_addr <= host_addr_t'(i);
			if (to_dut) begin
				sd_buff_dout <= {img[base + 2 * i + 1], img[base + 2 * i]};
				sd_buff_wr   <= 1'b1;
				@(posedge clk_sys);
			end else begin
				// One cycle of read latency behind the address
				repeat (2) @(posedge clk_sys);
				w = sd_buff_din;
				img[base + 2 * i]     = w[7:0];
				img[base + 2 * i + 1] = w[15:8];
			end
			if ($urandom_range(0, 3) == 0) begin
				sd_buff_wr <= 1'b0;
				repeat ($urandom_range(1, GAP_MAX)) @(posedge clk_sys);
			end
		end
		sd_buff_wr <= 1'b0;
		sd_ack     <= 1'b0;
	endtask

	initial begin : host_model
		sd_ack       <= 1'b0;
		sd_buff_addr <= '0;
		sd_buff_dout <= '0;
		sd_buff_wr   <= 1'b0;
		forever begin
			@(posedge clk_sys);
			if (!reset && (sd_rd || sd_wr))
				serve_block(sd_rd, sd_lba);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// External memory model with random stalls
	//////////////////////////////////////////////////////////////////////

	initial begin : memory_model
		int stall_left;
		stall_left = -1;
		mem_ready <= 1'b0;
		mem_rdata <= '0;
		forever begin
			@(posedge clk_sys);
			if (mem_valid && mem_ready) begin
				if (mem_write)
					mem_model[mem_addr] = mem_wdata;
				mem_ready <= 1'b0;
				stall_left = -1;
			end else if (mem_valid) begin
				if (stall_left < 0)
					stall_left = int'($urandom_range(0, MAX_STALL));
				if (stall_left == 0) begin
					mem_ready <= 1'b1;
					mem_rdata <= mem_model[mem_addr];
				end else begin
					stall_left--;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	// Waits for bk_busy to rise and fall, watching bk_reload meanwhile
	task automatic await_operation(input logic expect_reload, output bit started);
		int n;
		bit reload_bad;
		n          = 0;
		reload_bad = 1'b0;
		while (!bk_busy && n < 4) begin
			@(posedge clk_sys);
			n++;
		end
		started = bk_busy;
		while (bk_busy) begin
			if (bk_reload !== expect_reload)
				reload_bad = 1'b1;
			@(posedge clk_sys);
		end
		check_true(!reload_bad, "bk_reload did not follow the operation");
		check_true(!bk_reload, "bk_reload still high after the operation");
	endtask

	task automatic expect_quiet(input string what);
		bit active;
		active = 1'b0;
		repeat (QUIET_CYC) begin
			@(posedge clk_sys);
			if (sd_rd || sd_wr || bk_busy)
				active = 1'b1;
		end
		check_true(!active, what);
	endtask

	task automatic mount_image();
		img_readonly <= 1'b0;
		img_mounted  <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic check_bram_image();
		for (int a = 0; a < BRAM_BYTES; a++)
			check_val($sformatf("image byte %0h", a), int'(bram_ref[a]), int'(img[a]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		bit         started;
		byte_t      v;
		bram_addr_t pick;
		void'($urandom(32'h052a_5327));
		reset         <= 1'b1;
		img_mounted   <= 1'b0;
		img_readonly  <= 1'b0;
		bk_load       <= 1'b0;
		bk_save       <= 1'b0;
		autosave      <= 1'b0;
		osd_status    <= 1'b0;
		cart_en       <= 1'b0;
		console_addr  <= '0;
		console_wdata <= '0;
		console_we    <= 1'b0;
		cart_write    <= 1'b0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);

		begin_test("no_mount");
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		expect_quiet("save request before any mount started the engine");
		end_test();

		begin_test("save_bram");
		mount_image();
		for (int a = 0; a < BRAM_BYTES; a++) begin
			v             = byte_t'($urandom);
			bram_ref[a]   = v;
			console_addr  <= bram_addr_t'(a);
			console_wdata <= v;
			console_we    <= 1'b1;
			@(posedge clk_sys);
		end
		console_we <= 1'b0;
		@(posedge clk_sys);
		lba_log.delete();
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		await_operation(1'b0, started);
		check_true(started, "save request did not start the engine");
		check_bram_image();
		check_val("block count", BRAM_BLOCKS, lba_log.size());
		for (int i = 0; i < lba_log.size(); i++)
			check_val($sformatf("lba %0d", i), i, int'(lba_log[i]));
		end_test();

		begin_test("save_cart");
		cart_en <= 1'b1;
		for (int a = 0; a < CART_BYTES; a++)
			mem_model[a] = byte_t'($urandom);
		bk_save <= 1'b1;
		@(posedge clk_sys);
		bk_save <= 1'b0;
		await_operation(1'b0, started);
		check_true(started, "save request did not start the engine");
		for (int k = 0; k < CART_BYTES; k++)
			check_val($sformatf("cart image byte %0h", k), int'(mem_model[k]),
				int'(img[BRAM_BYTES + k]));
		end_test();

		begin_test("load_all");
		for (int a = 0; a < IMG_BYTES; a++)
			img[a] = byte_t'($urandom);
		bk_load <= 1'b1;
		@(posedge clk_sys);
		bk_load <= 1'b0;
		await_operation(1'b1, started);
		check_true(started, "load request did not start the engine");
		for (int a = 0; a < BRAM_BYTES; a++) begin
			console_addr <= bram_addr_t'(a);
			repeat (2) @(posedge clk_sys);
			check_val($sformatf("bram byte %0h", a), int'(img[a]), int'(console_rdata));
			bram_ref[a] = img[a];
		end
		for (int k = 0; k < CART_BYTES; k++)
			check_val($sformatf("memory byte %0h", k), int'(img[BRAM_BYTES + k]),
				int'(mem_model[k]));
		end_test();

		begin_test("autosave");
		cart_en  <= 1'b0;
		autosave <= 1'b1;
		pick = bram_addr_t'($urandom);
		v    = byte_t'($urandom);
		console_addr  <= pick;
		console_wdata <= v;
		console_we    <= 1'b1;
		@(posedge clk_sys);
		console_we     <= 1'b0;
		bram_ref[pick] = v;
		repeat (2) @(posedge clk_sys);
		check_true(sav_pending, "console write did not set sav_pending");
		osd_status <= 1'b1;
		@(posedge clk_sys);
		await_operation(1'b0, started);
		check_true(started, "menu close with a pending change started no save");
		check_true(!sav_pending, "sav_pending still set after the autosave");
		check_bram_image();
		osd_status <= 1'b0;
		repeat (2) @(posedge clk_sys);
		osd_status <= 1'b1;
		expect_quiet("menu close with nothing pending started an operation");
		osd_status <= 1'b0;
		end_test();

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* project.f */
common/bk_pkg.sv
common/block_xfer_if.sv
common/host_buf_if.sv
hdl/ram_dual_width.sv
hdl/stage_stepper.sv
control/bk_control.sv
hdl/bram_backup_top.sv
bench/tb_bram_backup.sv

/* Makefile */
# Verilator build and run for the backup RAM engine testbench

VERILATOR ?= verilator
TOP       ?= tb_bram_backup
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
